//--- bench/tb_dram_cmd_top.sv
// Sends 40 requests; the DRAM side acks after 0 to 12 cycles, or after 20 during the slow phase
`timescale 1ns/1ps

module tb_dram_cmd_top
  import dram_cmd_pkg::*;
();

  localparam int N_REQ    = 40;
  localparam int CLK_HALF = 20;
  localparam int WDOG_CYC = N_REQ * 3 * 40 + 1000;  // Commands times worst spacing plus margin

  logic       clk;
  logic       rst_n;
  logic       host_req;
  host_req_t  host_cmd;
  logic       cmd_ack;
  logic       host_ack;
  isu_entry_t dram_cmd;
  logic       cmd_req;

  isu_entry_t exp_q[$];
  int         value_errors;
  int         proto_errors;
  int         observed;
  logic       slow_phase;
  integer     seed;
  integer     ack_seed;
  logic       prev_cmd_req;
  logic       prev_cmd_ack;
  logic       prev_host_req;
  logic       prev_host_ack;

  dram_cmd_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_cmd (host_cmd),
    .cmd_ack  (cmd_ack),
    .host_ack (host_ack),
    .dram_cmd (dram_cmd),
    .cmd_req  (cmd_req)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // One step of the closed-page sequence on bank 0
  function automatic isu_entry_t expected_cmds(input host_req_t r, input int step);
    isu_entry_t e;
    e = '0;
    case (step)
      0: begin
        e.cmd      = CMD_ACTIVE;
        e.addr.row = r.row;  // Row view
      end
      1: begin
        e.cmd          = r.is_write ? CMD_WRITE : CMD_READ;
        e.addr.col.col = r.col;  // Column view with ap and spare left clear
      end
      default: e.cmd = CMD_PRECHARGE;
    endcase
    return e;
  endfunction

  // Four-phase host transfer that queues the expectations as the request goes up
  task automatic send_request(input host_req_t r);
    int k;
    @(negedge clk);
    host_cmd = r;
    host_req = 1'b1;
    for (k = 0; k < 3; k++) begin
      exp_q.push_back(expected_cmds(r, k));
    end
    do @(negedge clk); while (!host_ack);
    host_req = 1'b0;
    while (host_ack) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // DRAM responder
  //////////////////////////////////////////////////////////////////////
  initial begin
    integer rnd;
    int     delay;
    forever begin
      @(negedge clk);
      if (cmd_req && !cmd_ack) begin
        rnd   = $random(ack_seed);
        delay = slow_phase ? 20 : int'(rnd[7:0]) % 13;
        repeat (delay) @(negedge clk);
        cmd_ack = 1'b1;
        while (cmd_req) @(negedge clk);
        cmd_ack = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare and handshake monitor on the values from before the edge
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    isu_entry_t want;
    if (rst_n) begin
      if (cmd_req && !prev_cmd_req) begin
        observed++;
        assert (!prev_cmd_ack) else begin
          $display("cmd_req rose at %0t while cmd_ack was still high", $time);
          proto_errors++;
        end
        assert (exp_q.size() != 0) else begin
          $display("Command %h arrived at %0t with nothing expected", dram_cmd, $time);
          proto_errors++;
        end
        if (exp_q.size() != 0) begin
          want = exp_q.pop_front();
          assert (dram_cmd.cmd == want.cmd) else begin
            $display("CHECK FAILED at %0t: dram_cmd.cmd expected %0d got %0d",
                     $time, want.cmd, dram_cmd.cmd);
            value_errors++;
          end
          assert (dram_cmd.addr == want.addr) else begin
            $display("CHECK FAILED at %0t: dram_cmd.addr expected %h got %h",
                     $time, want.addr, dram_cmd.addr);
            value_errors++;
          end
          assert (dram_cmd.bank == want.bank) else begin
            $display("CHECK FAILED at %0t: dram_cmd.bank expected %h got %h",
                     $time, want.bank, dram_cmd.bank);
            value_errors++;
          end
        end
      end
      if (host_ack && !prev_host_ack) begin
        assert (prev_host_req) else begin
          $display("host_ack rose at %0t without a pending host_req", $time);
          proto_errors++;
        end
      end
      if (!host_ack && prev_host_ack) begin
        assert (!prev_host_req) else begin
          $display("host_ack fell at %0t while host_req was still high", $time);
          proto_errors++;
        end
      end
    end
    prev_cmd_req  = cmd_req;
    prev_cmd_ack  = cmd_ack;
    prev_host_req = host_req;
    prev_host_ack = host_ack;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    host_req_t r;
    integer    rnd;
    int        i;
    seed          = 32'hb29ba6e1;
    ack_seed      = 32'hb29ba6e1;  // Separate stream for the responder
    rst_n         = 1'b0;
    host_req      = 1'b0;
    host_cmd      = '0;
    cmd_ack       = 1'b0;
    slow_phase    = 1'b0;
    value_errors  = 0;
    proto_errors  = 0;
    observed      = 0;
    prev_cmd_req  = 1'b0;
    prev_cmd_ack  = 1'b0;
    prev_host_req = 1'b0;
    prev_host_ack = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!host_ack && !cmd_req) else begin
      $display("host_ack or cmd_req not low after reset at %0t", $time);
      proto_errors++;
    end
    for (i = 0; i < N_REQ; i++) begin
      rnd = $random(seed);
      r   = rnd[24:0];
      if (i >= 10 && i < 18) r.is_write = (i % 2 == 0);  // Write then read pairs
      slow_phase = (i >= 24 && i < 32);                   // Back-pressure window
      send_request(r);
    end
    while (exp_q.size() != 0) @(negedge clk);
    slow_phase = 1'b0;
    repeat (50) @(negedge clk);  // Room for any stray extra command
    assert (observed == 3 * N_REQ) else begin
      $display("Saw %0d commands where %0d were expected", observed, 3 * N_REQ);
      proto_errors++;
    end
    $display("Value errors %0d, protocol errors %0d, commands seen %0d",
             value_errors, proto_errors, observed);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WDOG_CYC * 2 * CLK_HALF);
    $display("Watchdog expired after %0d cycles, the run hung with %0d commands outstanding",
             WDOG_CYC, exp_q.size());
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- flist.f
rtl/dram_cmd_pkg.sv
rtl/bank_fsm.sv
rtl/cmd_scheduler.sv
rtl/issue_fifo.sv
rtl/dram_cmd_top.sv
bench/tb_dram_cmd_top.sv

//--- rtl/bank_fsm.sv
// Closed-page bank sequencer; a request is taken only in IDLE and only after T_RP has elapsed
`timescale 1ns/1ps

module bank_fsm
  import dram_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       host_req,
  input  host_req_t  host_cmd,
  input  logic       bank_stall,
  output logic       host_ack,
  output bank_info_t bank_info
);

  bank_state_t           state;
  host_req_t             req_q;
  logic [TIMER_BITS-1:0] timer;
  logic                  cmd_state;
  logic                  issued;
  logic                  accept;

  // Command states hand a command to the scheduler
  assign cmd_state = (state == B_ACTIVE) || (state == B_READ) ||
                     (state == B_WRITE)  || (state == B_PRE);
  assign issued    = cmd_state && !bank_stall;
  assign accept    = (state == B_IDLE) && host_req && !host_ack && (timer >= T_RP);

  //////////////////////////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      host_ack <= 1'b0;
    end else if (accept) begin
      host_ack <= 1'b1;
    end else if (!host_req) begin
      host_ack <= 1'b0;  // Fourth phase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= host_cmd;
    end
  end

  // Restarts on every issued command, saturates otherwise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer <= TIMER_BITS'(T_RP);  // Bank starts precharged
    end else if (issued) begin
      timer <= '0;
    end else if (timer != '1) begin
      timer <= timer + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bank sequence
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= B_IDLE;
    end else begin
      case (state)
        B_IDLE:        if (accept) state <= B_ACT_CHECK;
        B_ACT_CHECK:   state <= B_ACTIVE;
        B_ACTIVE:      if (!bank_stall) state <= B_ACT_STANDBY;
        B_ACT_STANDBY: state <= req_q.is_write ? B_WRITE_CHECK : B_READ_CHECK;
        B_READ_CHECK:  if (timer >= T_RCD) state <= B_READ;
        B_WRITE_CHECK: if (timer >= T_RCD) state <= B_WRITE;
        B_READ,
        B_WRITE:       if (!bank_stall) state <= B_PRE_CHECK;
        // At least T_RCD cycles already spent before the column command
        B_PRE_CHECK:   if (timer >= T_RAS - T_RCD) state <= B_PRE;
        B_PRE:         if (!bank_stall) state <= B_IDLE;
        default:       state <= B_IDLE;
      endcase
    end
  end

  always_comb begin
    bank_info.bank_state = state;
    bank_info.addr       = '0;  // PRECHARGE and idle carry a zero address
    case (state)
      B_ACT_CHECK,
      B_ACTIVE:      bank_info.addr.row = req_q.row;
      B_ACT_STANDBY,
      B_READ_CHECK,
      B_READ,
      B_WRITE_CHECK,
      B_WRITE:       bank_info.addr.col.col = req_q.col;
      default:       bank_info.addr = '0;
    endcase
  end

  // Ack only answers a request that was already up
  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(host_ack) |-> $past(host_req));

endmodule

//--- rtl/cmd_scheduler.sv
// Single-bank scheduler; holds a READ for T_WTR after a WRITE and stalls on a full issue queue
`timescale 1ns/1ps

module cmd_scheduler
  import dram_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  bank_info_t bank_info,
  input  logic       isu_full,
  output logic       bank_stall,
  output isu_entry_t sch_entry,
  output logic       sch_issue
);

  sch_cmd_t              cmd;
  logic                  have_cmd;
  logic                  last_write;  // Direction of the last column command
  logic [TIMER_BITS-1:0] wtr_cnt;
  logic                  wtr_hold;
  logic                  wr_issue;
  logic                  rd_issue;

  //////////////////////////////////////////////////////////////////////
  // Bank state to command
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (bank_info.bank_state)
      B_ACTIVE: cmd = CMD_ACTIVE;
      B_READ:   cmd = CMD_READ;
      B_WRITE:  cmd = CMD_WRITE;
      B_PRE:    cmd = CMD_PRECHARGE;
      default:  cmd = CMD_NOP;  // Check and idle states
    endcase
  end

  assign have_cmd = (cmd != CMD_NOP);

  always_comb begin
    sch_entry.cmd  = cmd;
    sch_entry.addr = bank_info.addr;
    sch_entry.bank = '0;  // Bank 0 only
  end

  //////////////////////////////////////////////////////////////////////
  // Write to read turnaround
  //////////////////////////////////////////////////////////////////////
  assign wtr_hold   = (cmd == CMD_READ) && last_write && (wtr_cnt != '0);
  assign bank_stall = have_cmd && (isu_full || wtr_hold);
  assign sch_issue  = have_cmd && !bank_stall;
  assign wr_issue   = sch_issue && (cmd == CMD_WRITE);
  assign rd_issue   = sch_issue && (cmd == CMD_READ);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_write <= 1'b0;
    end else if (wr_issue) begin
      last_write <= 1'b1;
    end else if (rd_issue) begin
      last_write <= 1'b0;
    end
  end

  // Zero means a READ may go
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wtr_cnt <= '0;
    end else if (wr_issue) begin
      wtr_cnt <= TIMER_BITS'(T_WTR - 1);
    end else if (wtr_cnt != '0) begin
      wtr_cnt <= wtr_cnt - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // A full queue holds the bank on its pending command
  a_full_holds_bank: assert property (@(posedge clk) disable iff (!rst_n)
    have_cmd && isu_full |=> $stable(bank_info));

  // No READ within T_WTR cycles of a WRITE
  a_wtr_window: assert property (@(posedge clk) disable iff (!rst_n)
    wr_issue |=> (!rd_issue) [*(T_WTR - 1)]);

endmodule

//--- rtl/dram_cmd_pkg.sv
// One bank only and the bank field is always zero; no refresh, no data path, no open-page reuse
package dram_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////
  localparam int ROW_BITS   = 14;
  localparam int COL_BITS   = 10;
  // Row, or column plus the auto-precharge bit
  localparam int ADDR_BITS  = (ROW_BITS > COL_BITS + 1) ? ROW_BITS : COL_BITS + 1;
  localparam int BA_BITS    = 3;

  //////////////////////////////////////////////////////////////////////
  // Timing in clock cycles
  //////////////////////////////////////////////////////////////////////
  localparam int T_RCD      = 3;  // ACTIVE to READ/WRITE
  localparam int T_RAS      = 6;  // ACTIVE to PRECHARGE
  localparam int T_RP       = 3;  // PRECHARGE to next ACTIVE
  localparam int T_WTR      = 4;  // WRITE issue to READ issue
  localparam int ISU_DEPTH  = 4;  // Power of two
  localparam int TIMER_BITS = 8;

  typedef enum logic [3:0] {
    B_IDLE,
    B_ACT_CHECK,
    B_ACTIVE,
    B_ACT_STANDBY,
    B_READ_CHECK,
    B_READ,
    B_WRITE_CHECK,
    B_WRITE,
    B_PRE_CHECK,
    B_PRE
  } bank_state_t;

  typedef enum logic [2:0] {
    CMD_NOP,
    CMD_ACTIVE,
    CMD_READ,
    CMD_WRITE,
    CMD_PRECHARGE
  } sch_cmd_t;

  // Row view for ACTIVE, column view for READ and WRITE
  typedef union packed {
    logic [ROW_BITS-1:0] row;
    struct packed {
      logic [ADDR_BITS-COL_BITS-2:0] spare;  // Zero filled
      logic                          ap;     // Auto-precharge, kept clear
      logic [COL_BITS-1:0]           col;
    } col;
  } dram_addr_u;

  typedef struct packed {
    logic                is_write;
    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] col;
  } host_req_t;

  typedef struct packed {
    bank_state_t bank_state;
    dram_addr_u  addr;
  } bank_info_t;

  // Queue entry, also the command word seen by the DRAM
  typedef struct packed {
    sch_cmd_t           cmd;
    dram_addr_u         addr;
    logic [BA_BITS-1:0] bank;
  } isu_entry_t;

endpackage

//--- rtl/dram_cmd_top.sv
// Command path of a one-bank DRAM controller; no data, no refresh, commands only
`timescale 1ns/1ps

module dram_cmd_top
  import dram_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       host_req,
  input  host_req_t  host_cmd,
  input  logic       cmd_ack,
  output logic       host_ack,
  output isu_entry_t dram_cmd,
  output logic       cmd_req
);

  bank_info_t bank_info;
  logic       bank_stall;
  isu_entry_t sch_entry;
  logic       sch_issue;
  logic       isu_full;

  bank_fsm i_bank_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_req   (host_req),
    .host_cmd   (host_cmd),
    .bank_stall (bank_stall),
    .host_ack   (host_ack),
    .bank_info  (bank_info)
  );

  cmd_scheduler i_cmd_scheduler (
    .clk        (clk),
    .rst_n      (rst_n),
    .bank_info  (bank_info),
    .isu_full   (isu_full),
    .bank_stall (bank_stall),
    .sch_entry  (sch_entry),
    .sch_issue  (sch_issue)
  );

  issue_fifo i_issue_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .sch_entry (sch_entry),
    .sch_issue (sch_issue),
    .cmd_ack   (cmd_ack),
    .isu_full  (isu_full),
    .dram_cmd  (dram_cmd),
    .cmd_req   (cmd_req)
  );

endmodule

//--- rtl/issue_fifo.sv
// Issue queue of ISU_DEPTH entries (power of two); the head goes out on a four-phase req/ack
`timescale 1ns/1ps

module issue_fifo
  import dram_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  isu_entry_t sch_entry,
  input  logic       sch_issue,
  input  logic       cmd_ack,
  output logic       isu_full,
  output isu_entry_t dram_cmd,
  output logic       cmd_req
);

  isu_entry_t                   mem [ISU_DEPTH];
  logic [$clog2(ISU_DEPTH)-1:0] wr_ptr;
  logic [$clog2(ISU_DEPTH)-1:0] rd_ptr;
  logic [$clog2(ISU_DEPTH):0]   count;
  logic                         push;
  logic                         pop;

  assign push     = sch_issue;
  assign pop      = cmd_req && cmd_ack;  // Third phase retires the head
  assign isu_full = (count == ($clog2(ISU_DEPTH) + 1)'(ISU_DEPTH));
  assign dram_cmd = mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // Circular buffer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= sch_entry;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Requester, low is idle and high waits for ack
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_req <= 1'b0;
    end else if (!cmd_req) begin
      if (count != '0 && !cmd_ack) cmd_req <= 1'b1;  // Previous ack gone
    end else if (cmd_ack) begin
      cmd_req <= 1'b0;
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < ISU_DEPTH));

endmodule
